/* src/mult_settings.svh */
`ifndef MULT_SETTINGS_SVH
`define MULT_SETTINGS_SVH

// Width of operands and of the returned product.
`define WORD_W 64

// Reorder index width. The index vector carries one extra wrap bit.
`define ROB_IDX_W 5

// Physical register tag width.
`define PRF_IDX_W 6

// One bit per unresolved branch.
`define BR_MASK_W 4

// Partial-product stages; 2, 4 or 8 divide the word evenly.
`define MULT_STAGES 4

// Tag of the hardwired zero register, used for idle entries.
`define ZERO_REG 31

`endif

/* src/ooo_tag_pkg.sv */
`default_nettype none

`include "mult_settings.svh"

package ooo_tag_pkg;

	// Reorder buffer slot plus wrap bit.
	typedef logic [`ROB_IDX_W:0] rob_idx_t;

	// Destination physical register.
	typedef logic [`PRF_IDX_W-1:0] prf_tag_t;

	// Unresolved branches this op is speculative on.
	typedef logic [`BR_MASK_W-1:0] br_mask_t;

endpackage

`default_nettype wire

/* src/mult_data_pkg.sv */
`default_nettype none

`include "mult_settings.svh"

package mult_data_pkg;

	// Operand or product word.
	typedef logic [`WORD_W-1:0] word_t;

	// Raw instruction word.
	// Bit 12 picks the literal form, bits 20 to 13 hold the literal.
	typedef logic [31:0] inst_t;

	// Unsigned literal operand.
	typedef logic [7:0] imm_t;

endpackage

`default_nettype wire

/* src/mult_issue.sv */
`default_nettype none

`include "mult_settings.svh"

module mult_issue (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start_i,
	input  mult_data_pkg::word_t  opa_i,
	input  mult_data_pkg::word_t  opb_i,
	input  mult_data_pkg::inst_t  inst_i,
	input  ooo_tag_pkg::rob_idx_t rob_idx_i,
	input  ooo_tag_pkg::prf_tag_t dest_tag_i,
	input  ooo_tag_pkg::br_mask_t br_mask_i,
	input  logic                  stall_i,
	input  logic                  br_recovery_i,
	input  logic                  br_pred_correct_i,
	input  ooo_tag_pkg::br_mask_t br_tag_fix_i,
	output logic                  valid_o,
	output mult_data_pkg::word_t  mcand_o,
	output mult_data_pkg::word_t  mplier_o,
	output ooo_tag_pkg::rob_idx_t rob_idx_o,
	output ooo_tag_pkg::prf_tag_t dest_tag_o,
	output ooo_tag_pkg::br_mask_t br_mask_o
);

	mult_data_pkg::imm_t  imm_lit;
	mult_data_pkg::word_t mplier_sel;
	ooo_tag_pkg::br_mask_t mask_in;
	logic advance;
	logic kill;

	// Literal form replaces operand B.
	assign imm_lit    = inst_i[20:13];
	assign mplier_sel = inst_i[12] ? mult_data_pkg::word_t'(imm_lit) : opb_i;

	// Resolved bit drops off as the op enters.
	assign mask_in = br_pred_correct_i ? (br_mask_i & ~br_tag_fix_i) : br_mask_i;

	assign advance = !stall_i && !br_recovery_i;
	assign kill    = br_recovery_i && ((br_mask_o & br_tag_fix_i) != '0);

	always_ff @(posedge clock) begin
		if (reset || kill) begin
			valid_o    <= 1'b0;
			rob_idx_o  <= '0;
			dest_tag_o <= ooo_tag_pkg::prf_tag_t'(`ZERO_REG);
			br_mask_o  <= '0;
		end else if (advance) begin
			valid_o    <= start_i;
			rob_idx_o  <= rob_idx_i;
			dest_tag_o <= dest_tag_i;
			br_mask_o  <= mask_in;
		end
	end

	// Operands follow the valid bit.
	always_ff @(posedge clock) begin
		if (advance) begin
			mcand_o  <= opa_i;
			mplier_o <= mplier_sel;
		end
	end

	// Issue logic must not start an op into a frozen or flushing pipe.
	a_start_legal: assert property (@(posedge clock) disable iff (reset)
		start_i |-> (!stall_i && !br_recovery_i))
		else $error("mult_issue: start during stall or recovery");

	a_reset_idle: assert property (@(posedge clock)
		reset |=> !valid_o)
		else $error("mult_issue: valid set after reset");

endmodule

`default_nettype wire

/* src/mult_stage.sv */
`default_nettype none

`include "mult_settings.svh"

module mult_stage #(
	parameter int STAGE_BITS = 16
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  valid_i,
	input  mult_data_pkg::word_t  product_i,
	input  mult_data_pkg::word_t  mplier_i,
	input  mult_data_pkg::word_t  mcand_i,
	input  ooo_tag_pkg::rob_idx_t rob_idx_i,
	input  ooo_tag_pkg::prf_tag_t dest_tag_i,
	input  ooo_tag_pkg::br_mask_t br_mask_i,
	input  logic                  stall_i,
	input  logic                  br_recovery_i,
	input  logic                  br_pred_correct_i,
	input  ooo_tag_pkg::br_mask_t br_tag_fix_i,
	output logic                  valid_o,
	output mult_data_pkg::word_t  product_o,
	output mult_data_pkg::word_t  mplier_o,
	output mult_data_pkg::word_t  mcand_o,
	output ooo_tag_pkg::rob_idx_t rob_idx_o,
	output ooo_tag_pkg::prf_tag_t dest_tag_o,
	output ooo_tag_pkg::br_mask_t br_mask_o
);

	mult_data_pkg::word_t partial;
	mult_data_pkg::word_t partial_reg;
	mult_data_pkg::word_t product_reg;
	ooo_tag_pkg::br_mask_t mask_in;
	logic advance;
	logic kill;

	// Low slice of the multiplier times the full multiplicand.
	// The multiplicand is already shifted to this slice's weight.
	assign partial = mult_data_pkg::word_t'(mplier_i[STAGE_BITS-1:0]) * mcand_i;

	// Final add of the slice happens one stage late, on the output.
	assign product_o = product_reg + partial_reg;

	assign mask_in = br_pred_correct_i ? (br_mask_i & ~br_tag_fix_i) : br_mask_i;

	assign advance = !stall_i && !br_recovery_i;
	assign kill    = br_recovery_i && ((br_mask_o & br_tag_fix_i) != '0);

	always_ff @(posedge clock) begin
		if (reset || kill) begin
			valid_o    <= 1'b0;
			rob_idx_o  <= '0;
			dest_tag_o <= ooo_tag_pkg::prf_tag_t'(`ZERO_REG);
			br_mask_o  <= '0;
		end else if (advance) begin
			valid_o    <= valid_i;
			rob_idx_o  <= rob_idx_i;
			dest_tag_o <= dest_tag_i;
			br_mask_o  <= mask_in;
		end
	end

	// Datapath registers.
	always_ff @(posedge clock) begin
		if (advance) begin
			product_reg <= product_i;
			partial_reg <= partial;
			mplier_o    <= mplier_i >> STAGE_BITS;
			mcand_o     <= mcand_i << STAGE_BITS;
		end
	end

	// A killed entry must be gone on the next cycle, stall or not.
	a_kill_clears: assert property (@(posedge clock) disable iff (reset)
		(br_recovery_i && ((br_mask_o & br_tag_fix_i) != '0)) |=> !valid_o)
		else $error("mult_stage: entry survived branch kill");

endmodule

`default_nettype wire

/* src/mult_unit.sv */
`default_nettype none

`include "mult_settings.svh"

module mult_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start_i,
	input  mult_data_pkg::word_t  opa_i,
	input  mult_data_pkg::word_t  opb_i,
	input  mult_data_pkg::inst_t  inst_i,
	input  ooo_tag_pkg::rob_idx_t rob_idx_i,
	input  ooo_tag_pkg::prf_tag_t dest_tag_i,
	input  ooo_tag_pkg::br_mask_t br_mask_i,
	input  logic                  stall_i,
	input  logic                  br_recovery_i,
	input  logic                  br_pred_correct_i,
	input  ooo_tag_pkg::br_mask_t br_tag_fix_i,
	output mult_data_pkg::word_t  product_o,
	output ooo_tag_pkg::rob_idx_t rob_idx_o,
	output ooo_tag_pkg::prf_tag_t dest_tag_o,
	output ooo_tag_pkg::br_mask_t br_mask_o,
	output logic                  done_pre_o,
	output logic                  done_o
);

	localparam int STAGE_BITS = `WORD_W / `MULT_STAGES;

	// Index 0 is the issue register, index s+1 the output of stage s.
	logic                  valid_c    [0:`MULT_STAGES];
	mult_data_pkg::word_t  product_c  [0:`MULT_STAGES];
	mult_data_pkg::word_t  mplier_c   [0:`MULT_STAGES];
	mult_data_pkg::word_t  mcand_c    [0:`MULT_STAGES];
	ooo_tag_pkg::rob_idx_t rob_idx_c  [0:`MULT_STAGES];
	ooo_tag_pkg::prf_tag_t dest_tag_c [0:`MULT_STAGES];
	ooo_tag_pkg::br_mask_t br_mask_c  [0:`MULT_STAGES];

	mult_issue u_issue (
		.clock             (clock),
		.reset             (reset),
		.start_i           (start_i),
		.opa_i             (opa_i),
		.opb_i             (opb_i),
		.inst_i            (inst_i),
		.rob_idx_i         (rob_idx_i),
		.dest_tag_i        (dest_tag_i),
		.br_mask_i         (br_mask_i),
		.stall_i           (stall_i),
		.br_recovery_i     (br_recovery_i),
		.br_pred_correct_i (br_pred_correct_i),
		.br_tag_fix_i      (br_tag_fix_i),
		.valid_o           (valid_c[0]),
		.mcand_o           (mcand_c[0]),
		.mplier_o          (mplier_c[0]),
		.rob_idx_o         (rob_idx_c[0]),
		.dest_tag_o        (dest_tag_c[0]),
		.br_mask_o         (br_mask_c[0])
	);

	// Running product starts empty.
	assign product_c[0] = '0;

	for (genvar s = 0; s < `MULT_STAGES; s++) begin : g_stage
		mult_stage #(
			.STAGE_BITS (STAGE_BITS)
		) u_stage (
			.clock             (clock),
			.reset             (reset),
			.valid_i           (valid_c[s]),
			.product_i         (product_c[s]),
			.mplier_i          (mplier_c[s]),
			.mcand_i           (mcand_c[s]),
			.rob_idx_i         (rob_idx_c[s]),
			.dest_tag_i        (dest_tag_c[s]),
			.br_mask_i         (br_mask_c[s]),
			.stall_i           (stall_i),
			.br_recovery_i     (br_recovery_i),
			.br_pred_correct_i (br_pred_correct_i),
			.br_tag_fix_i      (br_tag_fix_i),
			.valid_o           (valid_c[s+1]),
			.product_o         (product_c[s+1]),
			.mplier_o          (mplier_c[s+1]),
			.mcand_o           (mcand_c[s+1]),
			.rob_idx_o         (rob_idx_c[s+1]),
			.dest_tag_o        (dest_tag_c[s+1]),
			.br_mask_o         (br_mask_c[s+1])
		);
	end

	// Early done lets wakeup start a cycle ahead.
	assign done_pre_o = valid_c[`MULT_STAGES-1];
	assign done_o     = valid_c[`MULT_STAGES];
	assign product_o  = product_c[`MULT_STAGES];
	assign rob_idx_o  = rob_idx_c[`MULT_STAGES];
	assign dest_tag_o = dest_tag_c[`MULT_STAGES];
	assign br_mask_o  = br_mask_c[`MULT_STAGES];

endmodule

`default_nettype wire

/* sim/mult_tb.sv */
`default_nettype none

`include "mult_settings.svh"

module mult_tb;

	// Rough cycle budget of all tests together.
	localparam int TEST_CYCLES = 300;

	typedef struct packed {
		mult_data_pkg::word_t  product;
		ooo_tag_pkg::rob_idx_t rob_idx;
		ooo_tag_pkg::prf_tag_t dest_tag;
		ooo_tag_pkg::br_mask_t br_mask;
		logic [31:0]           due;
	} entry_t;

	logic clock = 1'b0;
	logic reset;

	logic                  start_i;
	mult_data_pkg::word_t  opa_i;
	mult_data_pkg::word_t  opb_i;
	mult_data_pkg::inst_t  inst_i;
	ooo_tag_pkg::rob_idx_t rob_idx_i;
	ooo_tag_pkg::prf_tag_t dest_tag_i;
	ooo_tag_pkg::br_mask_t br_mask_i;
	logic                  stall_i;
	logic                  br_recovery_i;
	logic                  br_pred_correct_i;
	ooo_tag_pkg::br_mask_t br_tag_fix_i;

	mult_data_pkg::word_t  product_o;
	ooo_tag_pkg::rob_idx_t rob_idx_o;
	ooo_tag_pkg::prf_tag_t dest_tag_o;
	ooo_tag_pkg::br_mask_t br_mask_o;
	logic                  done_pre_o;
	logic                  done_o;

	// Expected ops in issue order; due is the edge after which the op sits at the output.
	entry_t entry_q[$];
	logic [31:0] cyc = '0;

	// Queue state as of the previous edge.
	logic                  q_empty = 1'b1;

	logic                  check_en = 1'b0;
	logic                  seen_done = 1'b0;
	logic                  exp_done = 1'b0;
	logic                  exp_pre = 1'b0;
	mult_data_pkg::word_t  exp_product = '0;
	ooo_tag_pkg::rob_idx_t exp_rob = '0;
	ooo_tag_pkg::prf_tag_t exp_dest = '0;
	ooo_tag_pkg::br_mask_t exp_mask = '0;

	ooo_tag_pkg::rob_idx_t next_rob = '0;
	ooo_tag_pkg::prf_tag_t next_dest = '0;

	integer seed = 32'hc1e5;
	int errors = 0;
	int errors_before = 0;
	int passed = 0;
	int failed = 0;

	mult_unit dut (
		.clock             (clock),
		.reset             (reset),
		.start_i           (start_i),
		.opa_i             (opa_i),
		.opb_i             (opb_i),
		.inst_i            (inst_i),
		.rob_idx_i         (rob_idx_i),
		.dest_tag_i        (dest_tag_i),
		.br_mask_i         (br_mask_i),
		.stall_i           (stall_i),
		.br_recovery_i     (br_recovery_i),
		.br_pred_correct_i (br_pred_correct_i),
		.br_tag_fix_i      (br_tag_fix_i),
		.product_o         (product_o),
		.rob_idx_o         (rob_idx_o),
		.dest_tag_o        (dest_tag_o),
		.br_mask_o         (br_mask_o),
		.done_pre_o        (done_pre_o),
		.done_o            (done_o)
	);

	always #10 clock = ~clock;

	// Reference model, advanced once per rising edge.
	always @(posedge clock) begin : ref_model
		entry_t e;
		mult_data_pkg::word_t mplier;
		logic d;
		logic p;
		cyc = cyc + 1;
		if (reset) begin
			entry_q.delete();
		end else if (br_recovery_i) begin
			for (int i = entry_q.size() - 1; i >= 0; i--) begin
				if ((entry_q[i].br_mask & br_tag_fix_i) != '0)
					entry_q.delete(i);
			end
			for (int i = 0; i < entry_q.size(); i++) begin
				e = entry_q[i];
				e.due = e.due + 1;
				entry_q[i] = e;
			end
		end else if (stall_i) begin
			for (int i = 0; i < entry_q.size(); i++) begin
				e = entry_q[i];
				e.due = e.due + 1;
				entry_q[i] = e;
			end
		end else begin
			// The op shown at the output leaves.
			if (entry_q.size() > 0 && entry_q[0].due < cyc)
				entry_q.delete(0);
			if (br_pred_correct_i) begin
				for (int i = 0; i < entry_q.size(); i++) begin
					e = entry_q[i];
					e.br_mask = e.br_mask & ~br_tag_fix_i;
					entry_q[i] = e;
				end
			end
			if (start_i) begin
				mplier = inst_i[12] ? {{(`WORD_W-8){1'b0}}, inst_i[20:13]} : opb_i;
				e.product  = opa_i * mplier;
				e.rob_idx  = rob_idx_i;
				e.dest_tag = dest_tag_i;
				e.br_mask  = br_pred_correct_i ? (br_mask_i & ~br_tag_fix_i) : br_mask_i;
				e.due      = cyc + `MULT_STAGES;
				entry_q.push_back(e);
			end
		end
		d = entry_q.size() > 0 && entry_q[0].due == cyc;
		p = 1'b0;
		for (int i = 0; i < entry_q.size(); i++) begin
			if (entry_q[i].due == cyc + 1)
				p = 1'b1;
		end
		exp_done <= d;
		exp_pre  <= p;
		if (d) begin
			exp_product <= entry_q[0].product;
			exp_rob     <= entry_q[0].rob_idx;
			exp_dest    <= entry_q[0].dest_tag;
			exp_mask    <= entry_q[0].br_mask;
			seen_done   <= 1'b1;
		end
		q_empty  <= (entry_q.size() == 0);
		check_en <= 1'b1;
	end

	task automatic flag_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("ERR time %0t %s expected %0h actual %0h", $time, name, expected, actual);
		errors = errors + 1;
	endtask

	a_done: assert property (@(posedge clock) check_en |-> (done_o == exp_done))
		else flag_mismatch("done_o", 64'($sampled(exp_done)), 64'($sampled(done_o)));

	a_done_pre: assert property (@(posedge clock) check_en |-> (done_pre_o == exp_pre))
		else flag_mismatch("done_pre_o", 64'($sampled(exp_pre)), 64'($sampled(done_pre_o)));

	a_product: assert property (@(posedge clock)
		(check_en && exp_done) |-> (product_o == exp_product))
		else flag_mismatch("product_o", $sampled(exp_product), $sampled(product_o));

	a_rob: assert property (@(posedge clock) (check_en && exp_done) |-> (rob_idx_o == exp_rob))
		else flag_mismatch("rob_idx_o", 64'($sampled(exp_rob)), 64'($sampled(rob_idx_o)));

	a_dest: assert property (@(posedge clock)
		(check_en && exp_done) |-> (dest_tag_o == exp_dest))
		else flag_mismatch("dest_tag_o", 64'($sampled(exp_dest)), 64'($sampled(dest_tag_o)));

	a_mask: assert property (@(posedge clock)
		(check_en && exp_done) |-> (br_mask_o == exp_mask))
		else flag_mismatch("br_mask_o", 64'($sampled(exp_mask)), 64'($sampled(br_mask_o)));

	// Until the first op completes the output carries the zero register.
	a_idle_dest: assert property (@(posedge clock)
		(check_en && !seen_done && !exp_done) |-> (dest_tag_o == `ZERO_REG))
		else flag_mismatch("dest_tag_o", 64'(`ZERO_REG), 64'($sampled(dest_tag_o)));

	function automatic mult_data_pkg::word_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic ooo_tag_pkg::br_mask_t rand_mask();
		return ooo_tag_pkg::br_mask_t'($random(seed));
	endfunction

	task automatic drive_idle();
		start_i           <= 1'b0;
		opa_i             <= '0;
		opb_i             <= '0;
		inst_i            <= '0;
		rob_idx_i         <= '0;
		dest_tag_i        <= ooo_tag_pkg::prf_tag_t'(`ZERO_REG);
		br_mask_i         <= '0;
		stall_i           <= 1'b0;
		br_recovery_i     <= 1'b0;
		br_pred_correct_i <= 1'b0;
		br_tag_fix_i      <= '0;
	endtask

	task automatic issue_op(input mult_data_pkg::word_t a, input mult_data_pkg::word_t b,
		input mult_data_pkg::inst_t inst, input ooo_tag_pkg::br_mask_t mask,
		input logic correct, input ooo_tag_pkg::br_mask_t fix);
		@(posedge clock);
		drive_idle();
		start_i           <= 1'b1;
		opa_i             <= a;
		opb_i             <= b;
		inst_i            <= inst;
		rob_idx_i         <= next_rob;
		dest_tag_i        <= next_dest;
		br_mask_i         <= mask;
		br_pred_correct_i <= correct;
		br_tag_fix_i      <= fix;
		next_rob  = next_rob + 1'b1;
		next_dest = next_dest + 1'b1;
	endtask

	task automatic issue_random(input logic imm_form, input ooo_tag_pkg::br_mask_t mask);
		mult_data_pkg::inst_t inst;
		inst = $random(seed);
		inst[12] = imm_form;
		issue_op(rand_word(), rand_word(), inst, mask, 1'b0, '0);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			drive_idle();
		end
	endtask

	task automatic stall_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			drive_idle();
			stall_i <= 1'b1;
		end
	endtask

	task automatic recovery_pulse(input ooo_tag_pkg::br_mask_t fix);
		@(posedge clock);
		drive_idle();
		br_recovery_i <= 1'b1;
		br_tag_fix_i  <= fix;
	endtask

	task automatic correct_pulse(input ooo_tag_pkg::br_mask_t fix);
		@(posedge clock);
		drive_idle();
		br_pred_correct_i <= 1'b1;
		br_tag_fix_i      <= fix;
	endtask

	// Wait until every expected op has left, then let the last checks run.
	// The first two cycles let the model take in the last driven inputs.
	task automatic end_test(input string name);
		idle_cycles(2);
		while (!q_empty)
			idle_cycles(1);
		idle_cycles(2);
		if (errors == errors_before) begin
			passed++;
			$display("Test %s: pass", name);
		end else begin
			failed++;
			$display("Test %s: fail with %0d mismatches", name, errors - errors_before);
		end
		errors_before = errors;
	endtask

	initial begin : stimulus
		logic [31:0] r;
		reset <= 1'b1;
		drive_idle();
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		idle_cycles(6);
		end_test("reset_idle");

		// Edge operands first.
		issue_op('1, '1, '0, 4'b0000, 1'b0, '0);
		issue_op('0, rand_word(), '0, 4'b0001, 1'b0, '0);
		issue_op(rand_word(), '0, '0, 4'b0010, 1'b0, '0);
		issue_op(64'd1, '1, '0, 4'b0100, 1'b0, '0);
		issue_op('1, 64'd2, '0, 4'b1000, 1'b0, '0);
		issue_op(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0001, '0, '0, 1'b0, '0);
		repeat (8) issue_random(1'b0, rand_mask());
		end_test("back_to_back");

		// Literal 0xff and literal 0, operand B must be ignored.
		issue_op('1, rand_word(), {11'd0, 8'hff, 1'b1, 12'd0}, '0, 1'b0, '0);
		issue_op(rand_word(), rand_word(), {11'h7ff, 8'h00, 1'b1, 12'hfff}, '0, 1'b0, '0);
		repeat (8) issue_random(1'b1, rand_mask());
		end_test("immediate");

		for (int i = 0; i < 12; i++) begin
			issue_random(i[0], rand_mask());
			r = $random(seed);
			if (r[1:0] == 2'b00)
				stall_cycles(1 + int'(r[3:2]));
		end
		idle_cycles(2);
		stall_cycles(4);
		end_test("stall");

		issue_random(1'b0, 4'b0010);
		issue_random(1'b0, 4'b0001);
		issue_random(1'b1, 4'b0110);
		issue_random(1'b0, 4'b0000);
		issue_random(1'b0, 4'b1010);
		recovery_pulse(4'b0010);
		repeat (6) issue_random(1'b0, rand_mask());
		idle_cycles(1);
		recovery_pulse(4'b1000);
		end_test("recovery");

		issue_random(1'b0, 4'b0100);
		issue_random(1'b0, 4'b0101);
		issue_random(1'b1, 4'b1100);
		// Resolve branch 2 while an op dependent on it issues.
		issue_op(rand_word(), rand_word(), '0, 4'b0110, 1'b1, 4'b0100);
		issue_random(1'b0, 4'b0100);
		correct_pulse(4'b0001);
		issue_random(1'b0, 4'b0101);
		// Only the ops issued after the resolution still depend on branch 2.
		recovery_pulse(4'b0100);
		end_test("predict_correct");

		$display("Tests passed: %0d, failed: %0d, mismatches: %0d", passed, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(TEST_CYCLES * 20 + 2000);
		$display("Timeout: the tests did not finish within the cycle budget");
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/ooo_tag_pkg.sv
src/mult_data_pkg.sv
src/mult_issue.sv
src/mult_stage.sv
src/mult_unit.sv
sim/mult_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the multiply unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module mult_tb -o mult_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mult_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1
